//--- rvseed_div.f
+incdir+logic
logic/div_pkg.sv
logic/div_stage_if.sv
logic/div_operand_prep.sv
logic/divider_cell.sv
logic/div_pipeline.sv
logic/div_result_fix.sv
logic/div_unit.sv
sim/div_sva.sv
sim/div_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the divider testbench with Verilator, run it, and grade the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f rvseed_div.f --top-module div_tb -Mdir obj_dir -o div_sim
if [ $? -ne 0 ]; then
    echo "run_sim: verilator build failed"
    exit 1
fi

./obj_dir/div_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "run_sim: simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
    echo "run_sim: PASS"
    exit 0
fi
echo "run_sim: FAIL"
exit 1

//--- sim/div_tb.sv
`include "div_defs.svh"

module div_tb import div_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 5;
    localparam int NUM_CYCLES   = 400;  // issue-or-idle slots
    localparam int QUIET_CYCLES = 10;   // watch for stray results after the drain
    localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_CYCLES + `DIV_LATENCY + 50;

    localparam xlen_t MOST_NEG = {1'b1, {(`DIV_XLEN-1){1'b0}}};

    logic    clk;
    logic    rst;
    logic    in_valid;
    div_op_e op;
    xlen_t   dividend;
    xlen_t   divisor;
    logic    out_valid;
    xlen_t   result;

    logic [31:0] rng_state;
    int          cycle_cnt;
    int          err_cnt;
    int          issue_cnt;

    // one entry per op in flight, oldest first
    xlen_t   exp_result_q[$];
    int      exp_due_q[$];
    div_op_e exp_op_q[$];

    div_unit u_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .op        (op),
        .dividend  (dividend),
        .divisor   (divisor),
        .out_valid (out_valid),
        .result    (result)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    // RISC-V M-extension divide semantics
    function automatic xlen_t div_model(input div_op_e o, input xlen_t a, input xlen_t b);
        logic                        is_signed;
        logic signed [`DIV_XLEN-1:0] sa;
        logic signed [`DIV_XLEN-1:0] sb;
        xlen_t                       q;
        xlen_t                       r;
        is_signed = (o == OP_DIV) || (o == OP_REM);
        sa = a;
        sb = b;
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (is_signed && a == MOST_NEG && b == '1) begin
            q = a;  // overflow wraps back to the dividend
            r = '0;
        end else if (is_signed) begin
            q = sa / sb;  // truncates toward zero
            r = sa % sb;  // sign of the dividend
        end else begin
            q = a / b;
            r = a % b;
        end
        return ((o == OP_REM) || (o == OP_REMU)) ? r : q;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic drive_op(input div_op_e o, input xlen_t a, input xlen_t b);
        in_valid <= 1'b1;
        op       <= o;
        dividend <= a;
        divisor  <= b;
        exp_result_q.push_back(div_model(o, a, b));
        exp_op_q.push_back(o);
        exp_due_q.push_back(cycle_cnt + 1 + `DIV_LATENCY);  // dut samples next edge
        issue_cnt++;
    endtask

    initial begin
        logic [31:0] r_ctl;
        logic [31:0] r_a;
        logic [31:0] r_b;
        xlen_t       a;
        xlen_t       b;
        clk       = 1'b0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        op        = OP_DIV;
        dividend  = '0;
        divisor   = '0;
        rng_state = 32'h694b;
        cycle_cnt = 0;
        err_cnt   = 0;
        issue_cnt = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(posedge clk);
            next_rand(r_ctl);
            next_rand(r_a);
            next_rand(r_b);
            a = r_a;
            b = r_b;
            // bias some draws toward the corner cases
            case (r_ctl[7:4])
                4'd0: b = '0;
                4'd1: begin
                    a = MOST_NEG;
                    b = '1;
                end
                4'd2: b = {24'h0, r_b[7:0]};
                4'd3: b = {24'hff_ffff, r_b[7:0]};  // small negative
                4'd4: a = {16'h0, r_a[15:0]};
                default: ;
            endcase
            if (r_ctl[1:0] != 2'b00) begin
                drive_op(div_op_e'(r_ctl[3:2]), a, b);
            end else begin
                in_valid <= 1'b0;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;

        // last op is due a fixed latency after its strobe
        repeat (`DIV_LATENCY) @(posedge clk);
        repeat (QUIET_CYCLES) @(posedge clk);

        if (exp_result_q.size() != 0) begin
            $display("%0d results still outstanding at the end", exp_result_q.size());
            err_cnt++;
        end
        $display("issued %0d ops, errors: %0d", issue_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // outputs are settled half a cycle after the edge
    always @(negedge clk) begin
        xlen_t   want;
        int      due;
        div_op_e want_op;
        if (rst) begin
            if (out_valid !== 1'b0) begin
                $display("out_valid is not low during reset");
                err_cnt++;
            end
        end else if (out_valid === 1'b1) begin
            if (exp_result_q.size() == 0) begin
                $display("out_valid high at cycle %0d with no op in flight", cycle_cnt);
                err_cnt++;
            end else begin
                want    = exp_result_q.pop_front();
                due     = exp_due_q.pop_front();
                want_op = exp_op_q.pop_front();
                check_value($sformatf("result %s", want_op.name()), result, want);
                check_value("out_valid cycle", cycle_cnt, due);
            end
        end else if (out_valid !== 1'b0) begin
            $display("out_valid is unknown at cycle %0d", cycle_cnt);
            err_cnt++;
        end
    end

    always @(posedge clk) begin
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with %0d results outstanding",
                     cycle_cnt, exp_result_q.size());
            $display("issued %0d ops, errors: %0d", issue_cnt, err_cnt + 1);
            $display("Done: errors found");
            $finish;
        end
    end

endmodule

//--- sim/div_sva.sv
`include "div_defs.svh"

module div_sva import div_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  in_valid,
    input logic  out_valid,
    input xlen_t result
);

    timeunit 1ns;
    timeprecision 1ps;

    // every strobe comes back after the fixed latency
    a_latency: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> ##`DIV_LATENCY out_valid)
        else $error("out_valid missing after in_valid");

    // no result without a strobe that far back
    a_no_orphan: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> $past(in_valid, `DIV_LATENCY))
        else $error("out_valid without a matching in_valid");

    // reset clears the result strobe
    a_reset_low: assert property (@(posedge clk)
        rst |=> !out_valid)
        else $error("out_valid high during reset");

    a_result_known: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> !$isunknown(result))
        else $error("result unknown while out_valid is high");

endmodule

bind div_unit div_sva u_sva (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .result    (result)
);

//--- logic/div_unit.sv
module div_unit import div_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  div_op_e op,
    input  xlen_t   dividend,
    input  xlen_t   divisor,
    output logic    out_valid,
    output xlen_t   result
);

    div_stage_if stage_head ();  // prep output, combinational
    div_stage_if stage_tail ();  // after the last cell

    div_operand_prep u_prep (
        .in_valid (in_valid),
        .op       (op),
        .dividend (dividend),
        .divisor  (divisor),
        .stage    (stage_head)
    );

    // 32 cycles of compare and subtract
    div_pipeline u_pipe (
        .clk  (clk),
        .rst  (rst),
        .head (stage_head),
        .tail (stage_tail)
    );

    div_result_fix u_fix (
        .clk       (clk),
        .rst       (rst),
        .last      (stage_tail),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

//--- logic/div_result_fix.sv
module div_result_fix import div_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    div_stage_if.dst last,
    output logic     out_valid,
    output xlen_t    result
);

    xlen_t quo_fix;
    xlen_t rem_fix;

    always_comb begin
        quo_fix = last.neg_quo ? (~last.quo + 1'b1) : last.quo;
        rem_fix = last.neg_rem ? (~last.rem + 1'b1) : last.rem;
        // RISC-V rule for a zero divisor overrides the arithmetic
        if (last.dz) begin
            quo_fix = '1;
            rem_fix = last.dvd_raw;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= last.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (last.valid) begin
            result <= last.sel_rem ? rem_fix : quo_fix;
        end
    end

endmodule

//--- logic/div_pipeline.sv
`include "div_defs.svh"

module div_pipeline (
    input  logic     clk,
    input  logic     rst,
    div_stage_if.dst head,
    div_stage_if.src tail
);

    // links between neighbouring cells, link[i] sits after cell i
    div_stage_if link [`DIV_XLEN-1] ();

    genvar i;
    generate
        for (i = 0; i < `DIV_XLEN; i++) begin : cell_gen
            if (i == 0) begin : first
                divider_cell u_cell (
                    .clk  (clk),
                    .rst  (rst),
                    .prev (head),
                    .next (link[0])
                );
            end else if (i == `DIV_XLEN - 1) begin : last
                // produces the final quotient bit
                divider_cell u_cell (
                    .clk  (clk),
                    .rst  (rst),
                    .prev (link[i-1]),
                    .next (tail)
                );
            end else begin : mid
                divider_cell u_cell (
                    .clk  (clk),
                    .rst  (rst),
                    .prev (link[i-1]),
                    .next (link[i])
                );
            end
        end
    endgenerate

endmodule

//--- logic/divider_cell.sv
`include "div_defs.svh"

module divider_cell import div_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    div_stage_if.dst prev,
    div_stage_if.src next
);

    logic [`DIV_XLEN:0] shifted;  // remainder with the next dividend bit
    logic [`DIV_XLEN:0] diff;     // trial subtraction, msb is the borrow
    logic               take;
    xlen_t              rem_next;
    xlen_t              dvd_next;
    xlen_t              quo_next;

    // one restoring step
    always_comb begin
        shifted = {prev.rem, prev.dvd[`DIV_XLEN-1]};
        diff    = shifted - {1'b0, prev.dsr};
        // shifted stays below twice the divisor, so no borrow means fits
        take    = ~diff[`DIV_XLEN];
        if (take) begin
            rem_next = diff[`DIV_XLEN-1:0];
        end else begin
            rem_next = shifted[`DIV_XLEN-1:0];
        end
        dvd_next = {prev.dvd[`DIV_XLEN-2:0], 1'b0};
        quo_next = {prev.quo[`DIV_XLEN-2:0], take};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            next.valid <= 1'b0;
        end else begin
            next.valid <= prev.valid;
        end
    end

    // payload only moves when a real op passes through
    always_ff @(posedge clk) begin
        if (prev.valid) begin
            next.rem     <= rem_next;
            next.dvd     <= dvd_next;
            next.dsr     <= prev.dsr;
            next.quo     <= quo_next;
            next.neg_quo <= prev.neg_quo;  // flags ride with their data
            next.neg_rem <= prev.neg_rem;
            next.sel_rem <= prev.sel_rem;
            next.dz      <= prev.dz;
            next.dvd_raw <= prev.dvd_raw;
        end
    end

endmodule

//--- logic/div_operand_prep.sv
`include "div_defs.svh"

module div_operand_prep import div_pkg::*; (
    input  logic     in_valid,
    input  div_op_e  op,
    input  xlen_t    dividend,
    input  xlen_t    divisor,
    div_stage_if.src stage
);

    logic  is_signed;  // DIV or REM
    logic  dvd_neg;
    logic  dsr_neg;
    xlen_t dvd_abs;
    xlen_t dsr_abs;

    // signed ops treat the operand msb as the sign
    always_comb begin
        is_signed = (op == OP_DIV) || (op == OP_REM);
        dvd_neg   = is_signed && dividend[`DIV_XLEN-1];
        dsr_neg   = is_signed && divisor[`DIV_XLEN-1];
    end

    // most negative value is its own two's complement magnitude
    always_comb begin
        dvd_abs = dvd_neg ? (~dividend + 1'b1) : dividend;
        dsr_abs = dsr_neg ? (~divisor + 1'b1) : divisor;
    end

    always_comb begin
        stage.valid   = in_valid;
        stage.rem     = '0;       // nothing shifted in yet
        stage.dvd     = dvd_abs;
        stage.dsr     = dsr_abs;
        stage.quo     = '0;
        stage.neg_quo = dvd_neg ^ dsr_neg;  // truncating division
        stage.neg_rem = dvd_neg;            // remainder follows the dividend
        stage.sel_rem = (op == OP_REM) || (op == OP_REMU);
        stage.dz      = (divisor == '0);
        stage.dvd_raw = dividend;
    end

endmodule

//--- logic/div_stage_if.sv
interface div_stage_if import div_pkg::*; ();

    logic  valid;    // stage holds an operation
    xlen_t rem;      // partial remainder
    xlen_t dvd;      // dividend bits still to shift in, msb first
    xlen_t dsr;      // absolute divisor
    xlen_t quo;      // quotient bits so far
    logic  neg_quo;  // negate quotient at the end
    logic  neg_rem;  // negate remainder at the end
    logic  sel_rem;  // return remainder instead of quotient
    logic  dz;       // divide by zero
    xlen_t dvd_raw;  // dividend as issued

    modport src (
        output valid, rem, dvd, dsr, quo,
        output neg_quo, neg_rem, sel_rem, dz, dvd_raw
    );

    modport dst (
        input valid, rem, dvd, dsr, quo,
        input neg_quo, neg_rem, sel_rem, dz, dvd_raw
    );

endinterface

//--- logic/div_pkg.sv
`include "div_defs.svh"

package div_pkg;

    // one operand or result word
    typedef logic [`DIV_XLEN-1:0] xlen_t;

    // low two bits of the M-extension funct3 for the divide group
    typedef enum logic [1:0] {
        OP_DIV  = 2'b00, // signed quotient
        OP_DIVU = 2'b01, // unsigned quotient
        OP_REM  = 2'b10, // signed remainder
        OP_REMU = 2'b11  // unsigned remainder
    } div_op_e;

endpackage

//--- logic/div_defs.svh
`ifndef DIV_DEFS_SVH
`define DIV_DEFS_SVH

// width of the operands and of the result word
`define DIV_XLEN 32

// one registered cell per quotient bit, then the fixup register
`define DIV_LATENCY (`DIV_XLEN + 1)

`endif
